// File: histPkg.sv
package histPkg;

    // detector sample and peak height width
    localparam int sampleWidth = 10;

    // upper height bits that select a bin
    localparam int binBits = 4;
    localparam int numBins = 1 << binBits;

    // per-bin counter width, counts saturate at all ones
    localparam int countWidth = 6;
    localparam logic [countWidth-1:0] countMax = '1;

    // one measured pulse, bin is the top binBits of height
    typedef struct packed {
        logic [sampleWidth-1:0] height;
        logic [binBits-1:0]     bin;
    } peakEvent;

    // readout payload, one per bin
    typedef struct packed {
        logic [binBits-1:0]    bin;
        logic [countWidth-1:0] count;
    } binRecord;

endpackage

// File: peakCapture.sv
`timescale 1ns/1ps

module peakCapture (
    input  logic                         clk,
    input  logic                         res,
    input  logic [histPkg::sampleWidth-1:0] sample,
    input  logic                         sampleValid,
    input  logic [histPkg::sampleWidth-1:0] threshold,
    output logic                         peakValid,
    output histPkg::peakEvent            peak
);
    import histPkg::*;

    logic                   inPulse;   // currently inside an above-threshold run
    logic [sampleWidth-1:0] runMax;    // largest sample seen in this run
    logic                   above;
    logic                   runEnd;
    logic                   newMax;

    // strictly greater, equal samples never open a run
    assign above = sample > threshold;

    // first accepted sample at or below threshold closes the run
    assign runEnd = sampleValid && !above && inPulse;

    // first sample of a run always becomes the max
    assign newMax = !inPulse || (sample > runMax);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            inPulse   <= 1'b0;
            runMax    <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= runEnd;    // one cycle after the terminator
            if (sampleValid) begin
                if (above) begin
                    inPulse <= 1'b1;
                    if (newMax) begin
                        runMax <= sample;
                    end
                end else begin
                    inPulse <= 1'b0;
                end
            end
        end
    end

    // event payload, only meaningful with peakValid
    always_ff @(posedge clk) begin
        if (runEnd) begin
            peak.height <= runMax;
            peak.bin    <= runMax[sampleWidth-1 -: binBits]; // top bits pick the bin
        end
    end

endmodule

// File: histAccumulator.sv
`timescale 1ns/1ps

module histAccumulator #(
    parameter logic [19:0] acqLength = 20'd1000
) (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           start,
    input  logic                           peakValid,
    input  histPkg::peakEvent              peak,
    input  logic                           readDone,
    input  logic [histPkg::binBits-1:0]    rdAddr,
    output logic [histPkg::countWidth-1:0] rdCount,
    output logic                           acqDone,
    output logic                           busy
);
    import histPkg::*;

    // bin memory plus one valid bit per bin
    logic [countWidth-1:0] binMem [numBins];
    logic [numBins-1:0]    binInit;

    logic        acqActive;    // window open
    logic [19:0] winCount;     // cycles spent inside the window
    logic        startOk;
    logic        winLast;
    logic        binWrite;

    logic [countWidth-1:0] curCount;
    logic [countWidth-1:0] nextCount;

    // start only counts when nothing else is running
    assign startOk = start && !busy;
    assign winLast = acqActive && (winCount == acqLength - 20'd1);

    // peaks outside the window are dropped here
    assign binWrite = acqActive && peakValid;

    // uninitialized bins read as zero
    assign curCount = binInit[peak.bin] ? binMem[peak.bin] : '0;

    // saturating increment
    always_comb begin
        if (curCount == countMax) begin
            nextCount = curCount;
        end else begin
            nextCount = curCount + 1'b1;
        end
    end

    // window counter and acquisition control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acqActive <= 1'b0;
            winCount  <= '0;
            acqDone   <= 1'b0;
            busy      <= 1'b0;
        end else begin
            acqDone <= winLast;
            if (startOk) begin
                acqActive <= 1'b1;
                winCount  <= '0;
                busy      <= 1'b1;
            end else if (winLast) begin
                acqActive <= 1'b0;
            end else if (acqActive) begin
                winCount <= winCount + 20'd1;
            end
            // busy holds through the readout
            if (readDone) begin
                busy <= 1'b0;
            end
        end
    end

    // initialized bits, cleared all at once on a new acquisition
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binInit <= '0;
        end else if (startOk) begin
            binInit <= '0;
        end else if (binWrite) begin
            binInit[peak.bin] <= 1'b1;
        end
    end

    // count storage, stale data is masked by binInit
    always_ff @(posedge clk) begin
        if (binWrite) begin
            binMem[peak.bin] <= nextCount;
        end
    end

    // read port for the readout sequencer
    always_comb begin
        if (binInit[rdAddr]) begin
            rdCount = binMem[rdAddr];
        end else begin
            rdCount = '0;
        end
    end

endmodule

// File: histReadout.sv
`timescale 1ns/1ps

module histReadout (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           acqDone,
    output logic [histPkg::binBits-1:0]    rdAddr,
    input  logic [histPkg::countWidth-1:0] rdCount,
    output logic                           binValid,
    output histPkg::binRecord              binOut,
    output logic                           readDone
);
    import histPkg::*;

    logic scanActive;   // walking through bins 1 and up
    logic scanRead;     // a bin is sampled this cycle
    logic lastBin;
    logic lastOut;

    // rdAddr idles at zero so bin 0 is read in the acqDone cycle
    assign scanRead = acqDone || scanActive;
    assign lastBin  = rdAddr == binBits'(numBins - 1);

    // final record is on the output
    assign lastOut = binValid && (binOut.bin == binBits'(numBins - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanActive <= 1'b0;
            rdAddr     <= '0;
            binValid   <= 1'b0;
            readDone   <= 1'b0;
        end else begin
            binValid <= scanRead;
            readDone <= lastOut;   // one cycle after bin 15
            if (scanRead) begin
                rdAddr <= rdAddr + 1'b1;    // wraps back to 0 after the last bin
                if (lastBin) begin
                    scanActive <= 1'b0;
                end else begin
                    scanActive <= 1'b1;
                end
            end
        end
    end

    // record payload, qualified by binValid
    always_ff @(posedge clk) begin
        if (scanRead) begin
            binOut.bin   <= rdAddr;
            binOut.count <= rdCount;
        end
    end

endmodule

// File: spectrometerTop.sv
`timescale 1ns/1ps

module spectrometerTop #(
    parameter logic [19:0] acqLength = 20'd1000
) (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            start,
    input  logic [histPkg::sampleWidth-1:0] sample,
    input  logic                            sampleValid,
    input  logic [histPkg::sampleWidth-1:0] threshold,
    output logic                            busy,
    output logic                            binValid,
    output histPkg::binRecord               binOut,
    output logic                            readDone
);
    import histPkg::*;

    // peak finder to histogram
    logic     peakValid;
    peakEvent peak;

    // histogram to readout
    logic                  acqDone;
    logic [binBits-1:0]    rdAddr;
    logic [countWidth-1:0] rdCount;

    peakCapture i_peakCapture (
        .clk         (clk),
        .res         (res),
        .sample      (sample),
        .sampleValid (sampleValid),
        .threshold   (threshold),
        .peakValid   (peakValid),
        .peak        (peak)
    );

    histAccumulator #(
        .acqLength (acqLength)
    ) i_histAccumulator (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .peakValid (peakValid),
        .peak      (peak),
        .readDone  (readDone),
        .rdAddr    (rdAddr),
        .rdCount   (rdCount),
        .acqDone   (acqDone),
        .busy      (busy)
    );

    histReadout i_histReadout (
        .clk      (clk),
        .res      (res),
        .acqDone  (acqDone),
        .rdAddr   (rdAddr),
        .rdCount  (rdCount),
        .binValid (binValid),
        .binOut   (binOut),
        .readDone (readDone)
    );

endmodule

// File: tbSpectrometer.sv
`timescale 1ns/1ps

module tbSpectrometer;
    import histPkg::*;

    localparam int acqLength = 2000;
    localparam int numTests  = 6;
    localparam int satCount  = (1 << countWidth) - 1;

    // table row with up to four pulse heights and their repeat counts
    typedef struct packed {
        logic [3:0][sampleWidth-1:0] height;
        logic [3:0][6:0]             reps;
        logic [sampleWidth-1:0]      thresh;
        logic                        busyStart;   // extra start while busy
        logic                        latePulses;  // pulses after the window closes
    } testRow;

    logic                   clk;
    logic                   res;
    logic                   start;
    logic [sampleWidth-1:0] sample;
    logic                   sampleValid;
    logic [sampleWidth-1:0] threshold;
    logic                   busy;
    logic                   binValid;
    binRecord               binOut;
    logic                   readDone;

    testRow   tests [numTests];
    binRecord recQ [$];         // records seen by the monitor
    int       doneCount = 0;
    int       cycleCnt = 0;
    int       startCycle = 0;
    int       latency = 0;
    bit       timing = 1'b0;
    int       errors = 0;
    int       checks = 0;
    int       failedTests = 0;

    spectrometerTop #(
        .acqLength (20'(acqLength))
    ) i_dut (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .sample      (sample),
        .sampleValid (sampleValid),
        .threshold   (threshold),
        .busy        (busy),
        .binValid    (binValid),
        .binOut      (binOut),
        .readDone    (readDone)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // outputs sampled mid-cycle away from the rising edge
    always @(negedge clk) begin
        cycleCnt++;
        if (start && !timing) begin
            startCycle = cycleCnt;
            timing = 1'b1;
        end
        if (binValid) recQ.push_back(binOut);
        if (readDone) begin
            doneCount++;
            latency = cycleCnt - startCycle;
            timing = 1'b0;
        end
    end

    task automatic checkValue(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic setRow(input int idx, input int h0, input int r0, input int h1,
                          input int r1, input int h2, input int r2, input int h3,
                          input int r3, input int thr, input bit busyStart,
                          input bit late);
        tests[idx].height[0] = sampleWidth'(h0);
        tests[idx].height[1] = sampleWidth'(h1);
        tests[idx].height[2] = sampleWidth'(h2);
        tests[idx].height[3] = sampleWidth'(h3);
        tests[idx].reps[0]   = 7'(r0);
        tests[idx].reps[1]   = 7'(r1);
        tests[idx].reps[2]   = 7'(r2);
        tests[idx].reps[3]   = 7'(r3);
        tests[idx].thresh    = sampleWidth'(thr);
        tests[idx].busyStart  = busyStart;
        tests[idx].latePulses = late;
    endtask

    task automatic pulseStart();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // four-step ramp then a zero terminator and an idle gap
    task automatic drivePulse(input logic [sampleWidth-1:0] height);
        int gap;
        gap = 1 + int'($urandom % 6);
        for (int step = 1; step <= 4; step++) begin
            @(posedge clk);
            sample      <= sampleWidth'((int'(height) * step) / 4);
            sampleValid <= 1'b1;
        end
        @(posedge clk);
        sample <= '0;
        repeat (gap) begin
            @(posedge clk);
            sample      <= '1;   // large but not qualified
            sampleValid <= 1'b0;
        end
    endtask

    task automatic runTest(input int idx);
        int       expCount [numBins];
        int       errBefore;
        int       waited;
        int       b;
        binRecord rec;
        errBefore = errors;
        foreach (expCount[i]) expCount[i] = 0;
        for (int j = 0; j < 4; j++) begin
            for (int k = 0; k < int'(tests[idx].reps[j]); k++) begin
                if (tests[idx].height[j] > tests[idx].thresh) begin
                    b = int'(tests[idx].height[j]) >> (sampleWidth - binBits);
                    if (expCount[b] < satCount) expCount[b]++;
                end
            end
        end
        @(posedge clk);
        threshold <= tests[idx].thresh;
        recQ.delete();
        doneCount = 0;
        pulseStart();
        repeat (3) @(posedge clk);
        if (tests[idx].busyStart) pulseStart(); // must be ignored
        repeat (3) @(posedge clk);
        for (int j = 0; j < 4; j++) begin
            for (int k = 0; k < int'(tests[idx].reps[j]); k++) begin
                drivePulse(tests[idx].height[j]);
            end
        end
        if (tests[idx].latePulses) begin
            // records appear only after the window closes
            waited = 0;
            while (recQ.size() == 0 && waited < acqLength + 50) begin
                @(posedge clk);
                waited++;
            end
            repeat (3) drivePulse(sampleWidth'(1000)); // first lands before bin 15 is read
        end
        waited = 0;
        while (doneCount == 0 && waited < acqLength + 50) begin
            @(posedge clk);
            waited++;
        end
        if (doneCount == 0) begin
            reportProblem($sformatf("test %0d readout never finished", idx));
        end else begin
            checkValue("start to readDone cycles", latency, acqLength + 18);
            for (int i = 0; i < recQ.size() && i < numBins; i++) begin
                rec = recQ[i];
                checkValue("binOut.bin", int'(rec.bin), i);
                checkValue($sformatf("binOut.count[%0d]", i), int'(rec.count),
                           expCount[i]);
            end
        end
        repeat (20) @(negedge clk);
        checkValue("busy after readout", int'(busy), 0);
        checkValue("readDone pulses", doneCount, 1);
        checkValue("records per readout", recQ.size(), numBins);
        if (errors != errBefore) failedTests++;
        $display("test %0d %s, %0d records, %0d errors", idx,
                 (errors == errBefore) ? "ok" : "FAILED", recQ.size(), errors - errBefore);
    endtask

    initial begin
        res         = 1'b0;
        start       = 1'b0;
        sample      = '0;
        sampleValid = 1'b0;
        threshold   = '0;
        void'($urandom(32'hc180d6fa));
        setRow(0, 0, 0, 0, 0, 0, 0, 0, 0, 100, 1'b0, 1'b0);       // empty run
        setRow(1, 150, 3, 400, 5, 700, 2, 1000, 4, 100, 1'b0, 1'b0);
        setRow(2, 300, 4, 301, 1, 500, 2, 0, 0, 300, 1'b0, 1'b0);  // equal never counts
        setRow(3, 200, 2, 0, 0, 0, 0, 0, 0, 50, 1'b0, 1'b0);
        setRow(4, 350, 2, 0, 0, 0, 0, 0, 0, 100, 1'b1, 1'b1);
        setRow(5, 600, 80, 900, 3, 64, 1, 0, 0, 30, 1'b0, 1'b0);  // saturation
        repeat (16) @(posedge clk);
        res <= 1'b1;
        @(negedge clk);
        checkValue("busy after reset", int'(busy), 0);
        checkValue("binValid after reset", int'(binValid), 0);
        checkValue("readDone after reset", int'(readDone), 0);
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 numTests, failedTests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // run limit scales with the table
    initial begin
        repeat (numTests * (acqLength + 200)) @(posedge clk);
        $display("timeout, the tests did not complete within the cycle limit");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: tb.f
histPkg.sv
peakCapture.sv
histAccumulator.sv
histReadout.sv
spectrometerTop.sv
tbSpectrometer.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbSpectrometer
FILELIST = tb.f
OBJDIR   = obj_dir
EXE      = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) histPkg.sv peakCapture.sv histAccumulator.sv histReadout.sv \
	spectrometerTop.sv tbSpectrometer.sv
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(OBJDIR)
